// File: verilog/arcade_ctrl_pkg.sv
//====================
// Arcade control front end shared definitions
// Key codes, joystick bit map, download index,
// PLL management registers and colour weights
//====================
`default_nettype none

package arcade_ctrl_pkg;

	// ====================
	// Keyboard and joysticks
	// ====================

	// PS/2 event word, bit 10 toggles per event, bit 9 is pressed
	localparam int unsigned KEY_W = 11;
	localparam int unsigned JOY_W = 16;

	// Set 2 scan codes of the cabinet keys
	localparam logic [7:0] KEY_START1  = 8'h16;
	localparam logic [7:0] KEY_START2  = 8'h1E;
	localparam logic [7:0] KEY_COIN1   = 8'h2E;
	localparam logic [7:0] KEY_COIN2   = 8'h36;
	localparam logic [7:0] KEY_SERVICE = 8'h46;
	localparam logic [7:0] KEY_PAUSE   = 8'h4D;
	// Cursor keys and left ctrl
	localparam logic [7:0] KEY_UP      = 8'h75;
	localparam logic [7:0] KEY_DOWN    = 8'h72;
	localparam logic [7:0] KEY_LEFT    = 8'h6B;
	localparam logic [7:0] KEY_RIGHT   = 8'h74;
	localparam logic [7:0] KEY_FIRE    = 8'h14;

	// Joystick word bit positions
	localparam int unsigned JB_RIGHT   = 0;
	localparam int unsigned JB_LEFT    = 1;
	localparam int unsigned JB_DOWN    = 2;
	localparam int unsigned JB_UP      = 3;
	localparam int unsigned JB_FIRE_L  = 4;
	localparam int unsigned JB_FIRE_R  = 5;
	localparam int unsigned JB_FLASH   = 6;
	localparam int unsigned JB_COIN    = 7;
	localparam int unsigned JB_START1  = 8;
	localparam int unsigned JB_START2  = 9;
	localparam int unsigned JB_PAUSE   = 10;

	// ====================
	// Download stream
	// ====================
	localparam logic [7:0] DIP_INDEX    = 8'd254;
	localparam int unsigned IOCTL_ADDR_W = 25;

	// ====================
	// PLL reconfiguration port
	// ====================
	localparam int unsigned CFG_ADDR_W = 6;
	localparam int unsigned CFG_DATA_W = 32;

	// Mode, M counter and start registers
	localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_MODE  = 6'd0;
	localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_M     = 6'd7;
	localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_START = 6'd2;

	// M counter words for native and ~1% slower pixel clock
	localparam logic [CFG_DATA_W-1:0] M_NATIVE     = 32'd3639383488;
	localparam logic [CFG_DATA_W-1:0] M_UNDERCLOCK = 32'd3268298314;

	// ====================
	// Colour resistor ladder
	// ====================
	localparam int unsigned COLOR_IN_W  = 5;
	localparam int unsigned COLOR_OUT_W = 8;

	// Index 0 is the weight of input bit 0
	localparam logic [COLOR_IN_W-1:0][COLOR_OUT_W-1:0] COLOR_WEIGHT = {
		8'h4D, 8'h40, 8'h35, 8'h24, 8'h19
	};

endpackage

`default_nettype wire

// File: verilog/cabinet_input.sv
//====================
// Cabinet input decoder
// Turns PS/2 key events into button states and merges
// them with two joystick words into cabinet controls
//====================
`default_nettype none

module cabinet_input (
	input  logic                              CLK_49M,
	input  logic                              rst_n,
	input  logic [arcade_ctrl_pkg::KEY_W-1:0] ps2_key,
	input  logic [arcade_ctrl_pkg::JOY_W-1:0] joystick_0,
	input  logic [arcade_ctrl_pkg::JOY_W-1:0] joystick_1,
	output logic [1:0]                        coin,
	output logic [1:0]                        start_buttons,
	output logic [3:0]                        p1_joystick,
	output logic [3:0]                        p2_joystick,
	output logic                              p1_fire,
	output logic                              p2_fire,
	output logic                              service,
	output logic [1:0]                        fire_r,
	output logic [1:0]                        flash,
	output logic                              pause_req
);

	// Fields of the event word
	logic       key_pressed;
	logic [7:0] key_code;
	logic       key_event;
	logic       toggle_q;

	// Key buttons, active high
	logic btn_start1, btn_start2, btn_coin1, btn_coin2;
	logic btn_service, btn_pause;
	logic btn_up, btn_down, btn_left, btn_right, btn_fire;

	assign key_pressed = ps2_key[9];
	assign key_code    = ps2_key[7:0];
	// Any flip of bit 10 is a new event
	assign key_event   = ps2_key[10] != toggle_q;

	// ====================
	// Key event decode
	// ====================
	always_ff @(posedge CLK_49M) begin
		if (!rst_n) begin
			// Take the current toggle so release of reset is no event
			toggle_q    <= ps2_key[10];
			btn_start1  <= 1'b0;
			btn_start2  <= 1'b0;
			btn_coin1   <= 1'b0;
			btn_coin2   <= 1'b0;
			btn_service <= 1'b0;
			btn_pause   <= 1'b0;
			btn_up      <= 1'b0;
			btn_down    <= 1'b0;
			btn_left    <= 1'b0;
			btn_right   <= 1'b0;
			btn_fire    <= 1'b0;
		end else begin
			toggle_q <= ps2_key[10];
			if (key_event) begin
				// Unknown codes fall through untouched
				case (key_code)
					arcade_ctrl_pkg::KEY_START1:  btn_start1  <= key_pressed;
					arcade_ctrl_pkg::KEY_START2:  btn_start2  <= key_pressed;
					arcade_ctrl_pkg::KEY_COIN1:   btn_coin1   <= key_pressed;
					arcade_ctrl_pkg::KEY_COIN2:   btn_coin2   <= key_pressed;
					arcade_ctrl_pkg::KEY_SERVICE: btn_service <= key_pressed;
					arcade_ctrl_pkg::KEY_PAUSE:   btn_pause   <= key_pressed;
					arcade_ctrl_pkg::KEY_UP:      btn_up      <= key_pressed;
					arcade_ctrl_pkg::KEY_DOWN:    btn_down    <= key_pressed;
					arcade_ctrl_pkg::KEY_LEFT:    btn_left    <= key_pressed;
					arcade_ctrl_pkg::KEY_RIGHT:   btn_right   <= key_pressed;
					arcade_ctrl_pkg::KEY_FIRE:    btn_fire    <= key_pressed;
					default: ;
				endcase
			end
		end
	end

	// ====================
	// Joystick merge
	// ====================
	// Keyboard drives player 1 only
	assign p1_joystick = ~{btn_right | joystick_0[arcade_ctrl_pkg::JB_RIGHT],
	                       btn_left  | joystick_0[arcade_ctrl_pkg::JB_LEFT],
	                       btn_down  | joystick_0[arcade_ctrl_pkg::JB_DOWN],
	                       btn_up    | joystick_0[arcade_ctrl_pkg::JB_UP]};
	assign p2_joystick = ~{joystick_1[arcade_ctrl_pkg::JB_RIGHT],
	                       joystick_1[arcade_ctrl_pkg::JB_LEFT],
	                       joystick_1[arcade_ctrl_pkg::JB_DOWN],
	                       joystick_1[arcade_ctrl_pkg::JB_UP]};
	assign p1_fire = ~(btn_fire | joystick_0[arcade_ctrl_pkg::JB_FIRE_L]);
	assign p2_fire = ~joystick_1[arcade_ctrl_pkg::JB_FIRE_L];

	// Second fire and flash bomb stay active high
	assign fire_r = {joystick_1[arcade_ctrl_pkg::JB_FIRE_R],
	                 joystick_0[arcade_ctrl_pkg::JB_FIRE_R]};
	assign flash  = {joystick_1[arcade_ctrl_pkg::JB_FLASH],
	                 joystick_0[arcade_ctrl_pkg::JB_FLASH]};

	// Coin 2 has no pad button
	assign coin          = ~{btn_coin2, btn_coin1 | joystick_0[arcade_ctrl_pkg::JB_COIN]};
	assign start_buttons = ~{btn_start2 | joystick_0[arcade_ctrl_pkg::JB_START2],
	                         btn_start1 | joystick_0[arcade_ctrl_pkg::JB_START1]};
	assign service       = ~btn_service;
	assign pause_req     = btn_pause | joystick_0[arcade_ctrl_pkg::JB_PAUSE];

	// Buttons only move on the edge that sees a toggle change
	a_btn_hold: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		!key_event |=> $stable({btn_start1, btn_start2, btn_coin1, btn_coin2,
		                        btn_service, btn_pause, btn_up, btn_down,
		                        btn_left, btn_right, btn_fire}));

endmodule

`default_nettype wire

// File: verilog/dip_switch_bank.sv
//====================
// DIP switch bank
// Captures DIP bytes from the download stream
//====================
`default_nettype none

module dip_switch_bank #(
	parameter int unsigned DIP_BANKS = 2
) (
	input  logic                                     CLK_49M,
	input  logic                                     rst_n,
	input  logic                                     ioctl_wr,
	input  logic [7:0]                               ioctl_index,
	input  logic [arcade_ctrl_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	input  logic [7:0]                               ioctl_dout,
	output logic [8*DIP_BANKS-1:0]                   dip_sw
);

	// Byte 0 in the low lane
	logic [DIP_BANKS-1:0][7:0] dip_q;
	logic                      dip_wr;

	// Only the DIP index is ours
	assign dip_wr = ioctl_wr && (ioctl_index == arcade_ctrl_pkg::DIP_INDEX);

	always_ff @(posedge CLK_49M) begin
		if (!rst_n) begin
			dip_q <= '0;
		end else if (dip_wr) begin
			// Addresses past the last bank match no lane
			for (int i = 0; i < DIP_BANKS; i++) begin
				if (ioctl_addr == arcade_ctrl_pkg::IOCTL_ADDR_W'(i)) begin
					dip_q[i] <= ioctl_dout;
				end
			end
		end
	end

	// Game side reads switches active low
	assign dip_sw = ~dip_q;

endmodule

`default_nettype wire

// File: verilog/pll_underclock_seq.sv
//====================
// PLL underclock sequencer
// Switches the pixel PLL M counter between native and
// underclocked words through the management port
//====================
`default_nettype none

module pll_underclock_seq (
	input  logic                                   CLK_49M,
	input  logic                                   rst_n,
	input  logic                                   underclock_sel,
	input  logic                                   cfg_waitrequest,
	output logic                                   cfg_write,
	output logic [arcade_ctrl_pkg::CFG_ADDR_W-1:0] cfg_address,
	output logic [arcade_ctrl_pkg::CFG_DATA_W-1:0] cfg_data
);

	logic       sel_meta;
	logic       sel_sync;
	logic       sel_applied;
	logic       sel_change;
	logic [2:0] state;

	// Stable and new select value
	assign sel_change = (sel_meta == sel_sync) && (sel_sync != sel_applied);

	// ====================
	// Sync and step counter
	// ====================
	always_ff @(posedge CLK_49M) begin
		if (!rst_n) begin
			sel_meta    <= 1'b0;
			sel_sync    <= 1'b0;
			sel_applied <= 1'b0;
			state       <= 3'd0;
			cfg_write   <= 1'b0;
		end else begin
			sel_meta  <= underclock_sel;
			sel_sync  <= sel_meta;
			cfg_write <= 1'b0;
			if (sel_change) begin
				// Restart wins over a running sequence
				sel_applied <= sel_sync;
				state       <= 3'd1;
			end else if (!cfg_waitrequest) begin
				// 7 wraps to 0 and ends the run
				if (state != 3'd0) begin
					state <= state + 3'd1;
				end
				cfg_write <= (state == 3'd1) || (state == 3'd5) || (state == 3'd7);
			end
		end
	end

	// ====================
	// Write address and data
	// ====================
	always_ff @(posedge CLK_49M) begin
		if (!sel_change && !cfg_waitrequest) begin
			case (state)
				3'd1: begin
					cfg_address <= arcade_ctrl_pkg::CFG_ADDR_MODE;
					cfg_data    <= '0;
				end
				3'd5: begin
					cfg_address <= arcade_ctrl_pkg::CFG_ADDR_M;
					cfg_data    <= sel_applied ? arcade_ctrl_pkg::M_UNDERCLOCK
					                           : arcade_ctrl_pkg::M_NATIVE;
				end
				3'd7: begin
					cfg_address <= arcade_ctrl_pkg::CFG_ADDR_START;
					cfg_data    <= '0;
				end
				default: ;
			endcase
		end
	end

	// Single-cycle strobes only
	a_write_pulse: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		cfg_write |=> !cfg_write);

	// A write was issued in a cycle the port was ready
	a_write_ready: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		cfg_write |-> $past(!cfg_waitrequest));

endmodule

`default_nettype wire

// File: verilog/color_weight_dac.sv
//====================
// Colour weight DAC
// Expands 5-bit RGB to 8-bit levels
// through the resistor ladder weights
//====================
`default_nettype none

module color_weight_dac (
	input  logic                                    CLK_49M,
	input  logic                                    rst_n,
	input  logic [arcade_ctrl_pkg::COLOR_IN_W-1:0]  r_in,
	input  logic [arcade_ctrl_pkg::COLOR_IN_W-1:0]  g_in,
	input  logic [arcade_ctrl_pkg::COLOR_IN_W-1:0]  b_in,
	output logic [arcade_ctrl_pkg::COLOR_OUT_W-1:0] r_out,
	output logic [arcade_ctrl_pkg::COLOR_OUT_W-1:0] g_out,
	output logic [arcade_ctrl_pkg::COLOR_OUT_W-1:0] b_out
);

	// Sum of weights over set bits, full scale is FFh
	function automatic logic [arcade_ctrl_pkg::COLOR_OUT_W-1:0] weigh(
		input logic [arcade_ctrl_pkg::COLOR_IN_W-1:0] level
	);
		logic [arcade_ctrl_pkg::COLOR_OUT_W-1:0] acc;
		acc = '0;
		for (int i = 0; i < arcade_ctrl_pkg::COLOR_IN_W; i++) begin
			if (level[i]) begin
				acc = acc + arcade_ctrl_pkg::COLOR_WEIGHT[i];
			end
		end
		return acc;
	endfunction

	// One register stage, new pixel every cycle
	always_ff @(posedge CLK_49M) begin
		if (!rst_n) begin
			r_out <= '0;
			g_out <= '0;
			b_out <= '0;
		end else begin
			r_out <= weigh(r_in);
			g_out <= weigh(g_in);
			b_out <= weigh(b_in);
		end
	end

endmodule

`default_nettype wire

// File: verilog/arcade_ctrl_top.sv
//====================
// Arcade control front end top level
// Inputs, DIP bank, PLL sequencer and colour DAC
//====================
`default_nettype none

module arcade_ctrl_top #(
	parameter int unsigned DIP_BANKS = 2
) (
	input  logic                                      CLK_49M,
	input  logic                                      rst_n,
	// Keyboard and pads
	input  logic [arcade_ctrl_pkg::KEY_W-1:0]         ps2_key,
	input  logic [arcade_ctrl_pkg::JOY_W-1:0]         joystick_0,
	input  logic [arcade_ctrl_pkg::JOY_W-1:0]         joystick_1,
	output logic [1:0]                                coin,
	output logic [1:0]                                start_buttons,
	output logic [3:0]                                p1_joystick,
	output logic [3:0]                                p2_joystick,
	output logic                                      p1_fire,
	output logic                                      p2_fire,
	output logic                                      service,
	output logic [1:0]                                fire_r,
	output logic [1:0]                                flash,
	output logic                                      pause_req,
	// Download stream
	input  logic                                      ioctl_wr,
	input  logic [7:0]                                ioctl_index,
	input  logic [arcade_ctrl_pkg::IOCTL_ADDR_W-1:0]  ioctl_addr,
	input  logic [7:0]                                ioctl_dout,
	output logic [8*DIP_BANKS-1:0]                    dip_sw,
	// PLL management
	input  logic                                      underclock_sel,
	input  logic                                      cfg_waitrequest,
	output logic                                      cfg_write,
	output logic [arcade_ctrl_pkg::CFG_ADDR_W-1:0]    cfg_address,
	output logic [arcade_ctrl_pkg::CFG_DATA_W-1:0]    cfg_data,
	// Video colour
	input  logic [arcade_ctrl_pkg::COLOR_IN_W-1:0]    r_in,
	input  logic [arcade_ctrl_pkg::COLOR_IN_W-1:0]    g_in,
	input  logic [arcade_ctrl_pkg::COLOR_IN_W-1:0]    b_in,
	output logic [arcade_ctrl_pkg::COLOR_OUT_W-1:0]   r_out,
	output logic [arcade_ctrl_pkg::COLOR_OUT_W-1:0]   g_out,
	output logic [arcade_ctrl_pkg::COLOR_OUT_W-1:0]   b_out
);

	cabinet_input i_cabinet_input (
		.CLK_49M, .rst_n, .ps2_key, .joystick_0, .joystick_1,
		.coin, .start_buttons, .p1_joystick, .p2_joystick,
		.p1_fire, .p2_fire, .service, .fire_r, .flash, .pause_req
	);

	dip_switch_bank #(
		.DIP_BANKS(DIP_BANKS)
	) i_dip_switch_bank (
		.CLK_49M, .rst_n, .ioctl_wr, .ioctl_index, .ioctl_addr, .ioctl_dout, .dip_sw
	);

	// Management port shares the core clock
	pll_underclock_seq i_pll_underclock_seq (
		.CLK_49M, .rst_n, .underclock_sel, .cfg_waitrequest,
		.cfg_write, .cfg_address, .cfg_data
	);

	color_weight_dac i_color_weight_dac (
		.CLK_49M, .rst_n, .r_in, .g_in, .b_in, .r_out, .g_out, .b_out
	);

endmodule

`default_nettype wire

// File: tests/tb_arcade_ctrl_checks.sv
//====================
// Arcade control testbench checks
// Stimulus for the five behaviours and the
// concurrent assertions that judge the DUT outputs
//====================
`default_nettype none

module tb_arcade_ctrl_checks #(
	parameter int DIP_BANKS    = 2,
	parameter int STIM_CYCLES  = 64,
	parameter int PLL_WAIT_MAX = 64
) (
	input  logic                                     CLK_49M,
	input  logic                                     rst_n,
	output logic [arcade_ctrl_pkg::KEY_W-1:0]        ps2_key,
	output logic [arcade_ctrl_pkg::JOY_W-1:0]        joystick_0,
	output logic [arcade_ctrl_pkg::JOY_W-1:0]        joystick_1,
	input  logic [1:0]                               coin,
	input  logic [1:0]                               start_buttons,
	input  logic [3:0]                               p1_joystick,
	input  logic [3:0]                               p2_joystick,
	input  logic                                     p1_fire,
	input  logic                                     p2_fire,
	input  logic                                     service,
	input  logic [1:0]                               fire_r,
	input  logic [1:0]                               flash,
	input  logic                                     pause_req,
	output logic                                     ioctl_wr,
	output logic [7:0]                               ioctl_index,
	output logic [arcade_ctrl_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	output logic [7:0]                               ioctl_dout,
	input  logic [8*DIP_BANKS-1:0]                   dip_sw,
	output logic                                     underclock_sel,
	output logic                                     cfg_waitrequest,
	input  logic                                     cfg_write,
	input  logic [arcade_ctrl_pkg::CFG_ADDR_W-1:0]   cfg_address,
	input  logic [arcade_ctrl_pkg::CFG_DATA_W-1:0]   cfg_data,
	output logic [arcade_ctrl_pkg::COLOR_IN_W-1:0]   r_in,
	output logic [arcade_ctrl_pkg::COLOR_IN_W-1:0]   g_in,
	output logic [arcade_ctrl_pkg::COLOR_IN_W-1:0]   b_in,
	input  logic [arcade_ctrl_pkg::COLOR_OUT_W-1:0]  r_out,
	input  logic [arcade_ctrl_pkg::COLOR_OUT_W-1:0]  g_out,
	input  logic [arcade_ctrl_pkg::COLOR_OUT_W-1:0]  b_out,
	output int                                       errors,
	output int                                       tests_run,
	output int                                       tests_failed,
	output logic                                     done
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int KEYS = 11;
	// Slot 0 right, 1 left, 2 down, 3 up, 4 fire, 5 start1, 6 start2,
	// 7 coin1, 8 coin2, 9 service, 10 pause
	localparam logic [KEYS-1:0][7:0] KEY_CODES = {
		arcade_ctrl_pkg::KEY_PAUSE, arcade_ctrl_pkg::KEY_SERVICE,
		arcade_ctrl_pkg::KEY_COIN2, arcade_ctrl_pkg::KEY_COIN1,
		arcade_ctrl_pkg::KEY_START2, arcade_ctrl_pkg::KEY_START1,
		arcade_ctrl_pkg::KEY_FIRE, arcade_ctrl_pkg::KEY_UP,
		arcade_ctrl_pkg::KEY_DOWN, arcade_ctrl_pkg::KEY_LEFT,
		arcade_ctrl_pkg::KEY_RIGHT
	};

	int                        seed;
	int                        mark;
	// Intended state, set when the stimulus is driven
	logic [KEYS-1:0]           exp_keys;
	logic [KEYS-1:0]           exp_keys_q;
	logic [DIP_BANKS-1:0][7:0] exp_dip;
	logic [DIP_BANKS-1:0][7:0] exp_dip_q;
	logic [23:0]               exp_rgb_q;
	logic                      exp_sel;
	logic                      seq_armed;
	int                        wr_total;
	int                        wr_start;
	int                        wr_seen;
	logic [19:0]               cabinet_outputs;
	logic [19:0]               cab_exp;
	logic [37:0]               exp_cfg;

	// ====================
	// Reference rules
	// ====================
	function automatic int key_slot(input logic [7:0] code);
		for (int i = 0; i < KEYS; i++) begin
			if (KEY_CODES[i] == code) begin
				return i;
			end
		end
		return -1;
	endfunction

	// Same bit order as cabinet_outputs
	function automatic logic [19:0] cabinet_expect(
		input logic [KEYS-1:0] k,
		input logic [15:0]     j0,
		input logic [15:0]     j1
	);
		logic [1:0] coins;
		logic [1:0] starts;
		logic [3:0] p1;
		logic [3:0] p2;
		logic [1:0] fire2;
		logic [1:0] bomb;
		coins  = ~{k[8], k[7] | j0[arcade_ctrl_pkg::JB_COIN]};
		starts = ~{k[6] | j0[arcade_ctrl_pkg::JB_START2],
		           k[5] | j0[arcade_ctrl_pkg::JB_START1]};
		p1     = ~{k[0] | j0[arcade_ctrl_pkg::JB_RIGHT], k[1] | j0[arcade_ctrl_pkg::JB_LEFT],
		           k[2] | j0[arcade_ctrl_pkg::JB_DOWN], k[3] | j0[arcade_ctrl_pkg::JB_UP]};
		// Player 2 has no keys
		p2     = ~{j1[arcade_ctrl_pkg::JB_RIGHT], j1[arcade_ctrl_pkg::JB_LEFT],
		           j1[arcade_ctrl_pkg::JB_DOWN], j1[arcade_ctrl_pkg::JB_UP]};
		fire2  = {j1[arcade_ctrl_pkg::JB_FIRE_R], j0[arcade_ctrl_pkg::JB_FIRE_R]};
		bomb   = {j1[arcade_ctrl_pkg::JB_FLASH], j0[arcade_ctrl_pkg::JB_FLASH]};
		return {coins, starts, p1, p2, ~(k[4] | j0[arcade_ctrl_pkg::JB_FIRE_L]),
		        ~j1[arcade_ctrl_pkg::JB_FIRE_L], ~k[9], fire2, bomb,
		        k[10] | j0[arcade_ctrl_pkg::JB_PAUSE]};
	endfunction

	function automatic logic [7:0] weight_sum(input logic [4:0] level);
		int sum;
		sum = 0;
		for (int i = 0; i < 5; i++) begin
			if (level[i]) begin
				sum += int'(arcade_ctrl_pkg::COLOR_WEIGHT[i]);
			end
		end
		return 8'(sum);
	endfunction

	assign cabinet_outputs = {coin, start_buttons, p1_joystick, p2_joystick, p1_fire,
	                          p2_fire, service, fire_r, flash, pause_req};
	assign cab_exp = cabinet_expect(exp_keys_q, joystick_0, joystick_1);
	assign wr_seen = wr_total - wr_start;
	assign exp_cfg = (wr_seen == 0) ? {arcade_ctrl_pkg::CFG_ADDR_MODE, 32'd0} :
	                 (wr_seen == 1) ? {arcade_ctrl_pkg::CFG_ADDR_M,
	                                   exp_sel ? arcade_ctrl_pkg::M_UNDERCLOCK
	                                           : arcade_ctrl_pkg::M_NATIVE} :
	                 (wr_seen == 2) ? {arcade_ctrl_pkg::CFG_ADDR_START, 32'd0} : '0;

	// One cycle of latency for keys, DIP bytes and colour
	always_ff @(posedge CLK_49M) begin
		exp_keys_q <= exp_keys;
		exp_dip_q  <= exp_dip;
		exp_rgb_q  <= {weight_sum(r_in), weight_sum(g_in), weight_sum(b_in)};
	end

	always_ff @(posedge CLK_49M) begin
		if (!rst_n) begin
			wr_total <= 0;
		end else if (cfg_write) begin
			wr_total <= wr_total + 1;
		end
	end

	task automatic report_mismatch(input string name, input logic [63:0] expected,
	                               input logic [63:0] actual);
		errors++;
		$display("[FAIL] %0d ns %s expected %h got %h", $time, name, expected, actual);
	endtask

	task automatic report_error(input string what);
		errors++;
		$display("Error at %0d ns: %s", $time, what);
	endtask

	// ====================
	// Assertions
	// ====================
	a_cabinet: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		cabinet_outputs == cab_exp)
	else report_mismatch("cabinet_outputs", $sampled(cab_exp), $sampled(cabinet_outputs));

	a_dip: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		dip_sw == ~exp_dip_q)
	else report_mismatch("dip_sw", $sampled(~exp_dip_q), $sampled(dip_sw));

	a_colour: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		{r_out, g_out, b_out} == exp_rgb_q)
	else report_mismatch("r_out,g_out,b_out", $sampled(exp_rgb_q),
	                     $sampled({r_out, g_out, b_out}));

	a_cfg_ready: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		cfg_write |-> !$past(cfg_waitrequest))
	else report_error("cfg_write followed a cycle with cfg_waitrequest high");

	a_cfg_count: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		cfg_write |-> seq_armed && wr_seen < 3)
	else report_error("cfg_write pulse without a pending select change");

	a_cfg_word: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		cfg_write |-> {cfg_address, cfg_data} == exp_cfg)
	else report_mismatch("cfg_address,cfg_data", $sampled(exp_cfg),
	                     $sampled({cfg_address, cfg_data}));

	// ====================
	// Stimulus
	// ====================
	task automatic send_key(input logic [7:0] code, input logic pressed);
		int slot;
		slot = key_slot(code);
		@(negedge CLK_49M);
		ps2_key = {~ps2_key[10], pressed, 1'b0, code};
		if (slot >= 0) begin
			exp_keys[slot] = pressed;
		end
		repeat (2) @(negedge CLK_49M);
	endtask

	task automatic press_keys();
		for (int i = 0; i < KEYS; i++) begin
			send_key(KEY_CODES[i], 1'b1);
			send_key(KEY_CODES[i], 1'b0);
		end
		// Unknown codes while fire is held
		send_key(arcade_ctrl_pkg::KEY_FIRE, 1'b1);
		send_key(8'h5A, 1'b0);
		send_key(8'h00, 1'b1);
		send_key(arcade_ctrl_pkg::KEY_FIRE, 1'b0);
	endtask

	task automatic wiggle_joysticks();
		repeat (STIM_CYCLES) begin
			@(negedge CLK_49M);
			joystick_0 = 16'($random(seed));
			joystick_1 = 16'($random(seed));
		end
		@(negedge CLK_49M);
		joystick_0 = '0;
		joystick_1 = '0;
	endtask

	task automatic dip_write(input logic [7:0] index, input logic [24:0] addr,
	                         input logic [7:0] data);
		@(negedge CLK_49M);
		ioctl_wr    = 1'b1;
		ioctl_index = index;
		ioctl_addr  = addr;
		ioctl_dout  = data;
		if (index == arcade_ctrl_pkg::DIP_INDEX && addr < DIP_BANKS) begin
			exp_dip[addr] = data;
		end
		@(negedge CLK_49M);
		ioctl_wr = 1'b0;
	endtask

	task automatic load_dips();
		dip_write(arcade_ctrl_pkg::DIP_INDEX, 25'd0, 8'($random(seed)));
		dip_write(arcade_ctrl_pkg::DIP_INDEX, 25'd1, 8'($random(seed)));
		// Foreign index and out-of-range addresses
		dip_write(8'd253, 25'd0, 8'hA5);
		dip_write(arcade_ctrl_pkg::DIP_INDEX, 25'd2, 8'h3C);
		dip_write(arcade_ctrl_pkg::DIP_INDEX, 25'h1000001, 8'hC3);
		dip_write(arcade_ctrl_pkg::DIP_INDEX, 25'd1, 8'($random(seed)));
	endtask

	task automatic switch_pll(input logic sel, input logic stall);
		int cycles;
		@(negedge CLK_49M);
		underclock_sel = sel;
		exp_sel        = sel;
		wr_start       = wr_total;
		seq_armed      = 1'b1;
		cycles         = 0;
		while (wr_total - wr_start < 3 && cycles < PLL_WAIT_MAX) begin
			@(negedge CLK_49M);
			cfg_waitrequest = stall ? 1'($random(seed)) : 1'b0;
			cycles++;
		end
		cfg_waitrequest = 1'b0;
		if (wr_total - wr_start < 3) begin
			report_error("PLL switch ended with fewer than three cfg_write pulses");
		end
		// Select held, so the port must stay quiet
		repeat (16) @(negedge CLK_49M);
	endtask

	task automatic stream_colours();
		repeat (STIM_CYCLES) begin
			@(negedge CLK_49M);
			r_in = 5'($random(seed));
			g_in = 5'($random(seed));
			b_in = 5'($random(seed));
		end
		@(negedge CLK_49M);
		r_in = '0;
		g_in = '0;
		b_in = '0;
		@(negedge CLK_49M);
	endtask

	task automatic close_test(input string name, input int errs_before);
		tests_run++;
		if (errors != errs_before) begin
			tests_failed++;
		end
		$display("Test %s: %s", name, (errors == errs_before) ? "ok" : "errors");
	endtask

	// ====================
	// Test sequence
	// ====================
	initial begin
		ps2_key         = '0;
		joystick_0      = '0;
		joystick_1      = '0;
		ioctl_wr        = 1'b0;
		ioctl_index     = '0;
		ioctl_addr      = '0;
		ioctl_dout      = '0;
		underclock_sel  = 1'b0;
		cfg_waitrequest = 1'b0;
		r_in            = '0;
		g_in            = '0;
		b_in            = '0;
		errors          = 0;
		tests_run       = 0;
		tests_failed    = 0;
		done            = 1'b0;
		exp_keys        = '0;
		exp_dip         = '0;
		exp_sel         = 1'b0;
		seq_armed       = 1'b0;
		wr_start        = 0;
		seed            = 2;
		@(posedge rst_n);
		@(negedge CLK_49M);
		mark = errors;
		press_keys();
		close_test("key events", mark);
		mark = errors;
		wiggle_joysticks();
		close_test("joystick merge", mark);
		mark = errors;
		load_dips();
		close_test("DIP capture", mark);
		mark = errors;
		switch_pll(1'b1, 1'b0);
		switch_pll(1'b0, 1'b0);
		switch_pll(1'b1, 1'b1);
		switch_pll(1'b0, 1'b1);
		close_test("PLL sequence", mark);
		mark = errors;
		stream_colours();
		close_test("colour weights", mark);
		done = 1'b1;
	end

endmodule

`default_nettype wire

// File: tests/tb_arcade_ctrl.sv
//====================
// Arcade control front end testbench
// Clock, reset, DUT, checks, watchdog and summary
//====================
`default_nettype none

module tb_arcade_ctrl;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 16;
	localparam int DIP_BANKS    = 2;
	localparam int STIM_CYCLES  = 64;
	localparam int PLL_WAIT_MAX = 64;

	// ====================
	// Cycle budget per test, in run order
	// ====================
	localparam int KEY_CYCLES  = 26 * 3;
	localparam int JOY_CYCLES  = STIM_CYCLES + 1;
	localparam int DIP_CYCLES  = 8 * 2;
	// Four switches, each with its idle tail
	localparam int PLL_CYCLES  = 4 * (PLL_WAIT_MAX + 17);
	localparam int COL_CYCLES  = STIM_CYCLES + 2;
	localparam int MARGIN      = 200;
	localparam int WATCHDOG_NS = CLK_PERIOD * (RESET_CYCLES + KEY_CYCLES + JOY_CYCLES
		+ DIP_CYCLES + PLL_CYCLES + COL_CYCLES + MARGIN);

	logic                                     CLK_49M;
	logic                                     rst_n;
	logic [arcade_ctrl_pkg::KEY_W-1:0]        ps2_key;
	logic [arcade_ctrl_pkg::JOY_W-1:0]        joystick_0;
	logic [arcade_ctrl_pkg::JOY_W-1:0]        joystick_1;
	logic [1:0]                               coin;
	logic [1:0]                               start_buttons;
	logic [3:0]                               p1_joystick;
	logic [3:0]                               p2_joystick;
	logic                                     p1_fire;
	logic                                     p2_fire;
	logic                                     service;
	logic [1:0]                               fire_r;
	logic [1:0]                               flash;
	logic                                     pause_req;
	logic                                     ioctl_wr;
	logic [7:0]                               ioctl_index;
	logic [arcade_ctrl_pkg::IOCTL_ADDR_W-1:0] ioctl_addr;
	logic [7:0]                               ioctl_dout;
	logic [8*DIP_BANKS-1:0]                   dip_sw;
	logic                                     underclock_sel;
	logic                                     cfg_waitrequest;
	logic                                     cfg_write;
	logic [arcade_ctrl_pkg::CFG_ADDR_W-1:0]   cfg_address;
	logic [arcade_ctrl_pkg::CFG_DATA_W-1:0]   cfg_data;
	logic [arcade_ctrl_pkg::COLOR_IN_W-1:0]   r_in;
	logic [arcade_ctrl_pkg::COLOR_IN_W-1:0]   g_in;
	logic [arcade_ctrl_pkg::COLOR_IN_W-1:0]   b_in;
	logic [arcade_ctrl_pkg::COLOR_OUT_W-1:0]  r_out;
	logic [arcade_ctrl_pkg::COLOR_OUT_W-1:0]  g_out;
	logic [arcade_ctrl_pkg::COLOR_OUT_W-1:0]  b_out;
	int                                       errors;
	int                                       tests_run;
	int                                       tests_failed;
	logic                                     done;

	arcade_ctrl_top i_dut (.*);

	// Stimulus and assertions sit beside the DUT
	tb_arcade_ctrl_checks #(
		.DIP_BANKS(DIP_BANKS),
		.STIM_CYCLES(STIM_CYCLES),
		.PLL_WAIT_MAX(PLL_WAIT_MAX)
	) i_checks (.*);

	initial begin
		CLK_49M = 1'b0;
		forever #(CLK_PERIOD / 2) CLK_49M = ~CLK_49M;
	end

	// Reset released on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(negedge CLK_49M);
		rst_n = 1'b1;
	end

	// ====================
	// Watchdog
	// ====================
	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		wait (done);
		$display("Summary: %0d tests run, %0d failed, %0d errors",
		         tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
verilog/arcade_ctrl_pkg.sv
verilog/cabinet_input.sv
verilog/dip_switch_bank.sv
verilog/pll_underclock_seq.sv
verilog/color_weight_dac.sv
verilog/arcade_ctrl_top.sv
tests/tb_arcade_ctrl_checks.sv
tests/tb_arcade_ctrl.sv

// File: Bender.yml
package:
  name: arcade_ctrl

sources:
  - target: any(rtl, test)
    files:
      - verilog/arcade_ctrl_pkg.sv
      - verilog/cabinet_input.sv
      - verilog/dip_switch_bank.sv
      - verilog/pll_underclock_seq.sv
      - verilog/color_weight_dac.sv
      - verilog/arcade_ctrl_top.sv
  - target: test
    files:
      - tests/tb_arcade_ctrl_checks.sv
      - tests/tb_arcade_ctrl.sv
